//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_lsu
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
lsu_pkg.sv
lsu_align.sv
lsu_ctrl.sv
data_sram.sv
lsu_top.sv
tb_lsu.sv

//--- data_sram.sv
// data memory with byte strobes and parameter-set stalls behind an AXI-lite style slave port
`timescale 1ns/1ps

module data_sram #(
	parameter int DEPTH_WORDS = 256,
	parameter int READY_WAIT  = 0,
	parameter int RESP_WAIT   = 0
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic [lsu_pkg::DATA_W-1:0] ar_addr_i,
	input  logic                       ar_valid_i,
	output logic                       ar_ready_o,
	output logic [lsu_pkg::DATA_W-1:0] r_data_o,
	output logic [1:0]                 r_resp_o,
	output logic                       r_valid_o,
	input  logic                       r_ready_i,
	input  logic [lsu_pkg::DATA_W-1:0] aw_addr_i,
	input  logic                       aw_valid_i,
	output logic                       aw_ready_o,
	input  logic [lsu_pkg::DATA_W-1:0] w_data_i,
	input  logic [3:0]                 w_strb_i,
	input  logic                       w_valid_i,
	output logic                       w_ready_o,
	output logic [1:0]                 b_resp_o,
	output logic                       b_valid_o,
	input  logic                       b_ready_i
);
	import lsu_pkg::*;

	localparam int IDX_W    = $clog2(DEPTH_WORDS);
	localparam int MAX_WAIT = (READY_WAIT > RESP_WAIT) ? READY_WAIT : RESP_WAIT;
	localparam int CNT_W    = $clog2(MAX_WAIT + 2);
	localparam logic [CNT_W-1:0]  RDY_CNT    = CNT_W'(READY_WAIT);
	localparam logic [CNT_W-1:0]  RSP_CNT    = CNT_W'(RESP_WAIT);
	localparam logic [DATA_W-1:0] ADDR_LIMIT = DATA_W'(4 * DEPTH_WORDS);

	typedef enum logic {S_REQ, S_RESP} state_e;

	bus_word_u        mem [DEPTH_WORDS];
	bus_word_u        wr_word;
	state_e           st_q;
	logic [CNT_W-1:0] cnt_q;
	logic [IDX_W-1:0] idx_q;
	logic             acc_err_q;
	logic             acc_write_q;
	logic             rd_req;
	logic             wr_req;
	logic             ar_fire;
	logic             wr_fire;
	logic             resp_up;
	logic             resp_fire;
	logic [1:0]       resp_code;

	// reads go first, writes need address and data together
	assign rd_req = ar_valid_i;
	assign wr_req = !ar_valid_i && aw_valid_i && w_valid_i;

	assign ar_ready_o = (st_q == S_REQ) && rd_req && (cnt_q == RDY_CNT);
	assign aw_ready_o = (st_q == S_REQ) && wr_req && (cnt_q == RDY_CNT);
	assign w_ready_o  = aw_ready_o;

	assign ar_fire = ar_valid_i && ar_ready_o;
	assign wr_fire = aw_valid_i && aw_ready_o && w_valid_i && w_ready_o;

	// response held up until the counter runs out, then kept until taken
	assign resp_up   = (st_q == S_RESP) && (cnt_q == RSP_CNT);
	assign r_valid_o = resp_up && !acc_write_q;
	assign b_valid_o = resp_up && acc_write_q;
	assign resp_fire = (r_valid_o && r_ready_i) || (b_valid_o && b_ready_i);

	assign resp_code = acc_err_q ? RESP_SLVERR : RESP_OKAY;
	assign r_resp_o  = resp_code;
	assign b_resp_o  = resp_code;
	assign r_data_o  = acc_err_q ? '0 : mem[idx_q];

	always_ff @(posedge clock) begin
		if (!rstn) begin
			st_q  <= S_REQ;
			cnt_q <= '0;
		end else begin
			case (st_q)
				S_REQ: begin
					if (ar_fire || wr_fire) begin
						st_q  <= S_RESP;
						cnt_q <= '0;
					end else if (rd_req || wr_req) begin
						if (cnt_q != RDY_CNT) cnt_q <= cnt_q + CNT_W'(1);
					end else begin
						cnt_q <= '0;
					end
				end
				S_RESP: begin
					if (resp_fire) begin
						st_q  <= S_REQ;
						cnt_q <= '0;
					end else if (cnt_q != RSP_CNT) begin
						cnt_q <= cnt_q + CNT_W'(1);
					end
				end
				default: st_q <= S_REQ;
			endcase
		end
	end

	// remember which word the response is for
	always_ff @(posedge clock) begin
		if (ar_fire) begin
			idx_q       <= ar_addr_i[IDX_W+1:2];
			acc_err_q   <= ar_addr_i >= ADDR_LIMIT;
			acc_write_q <= 1'b0;
		end else if (wr_fire) begin
			idx_q       <= aw_addr_i[IDX_W+1:2];
			acc_err_q   <= aw_addr_i >= ADDR_LIMIT;
			acc_write_q <= 1'b1;
		end
	end

	assign wr_word = w_data_i;

	// strobed lanes only, nothing written out of range
	always_ff @(posedge clock) begin
		if (wr_fire && aw_addr_i < ADDR_LIMIT) begin
			for (int i = 0; i < 4; i++) begin
				if (w_strb_i[i]) mem[aw_addr_i[IDX_W+1:2]].lane[i] <= wr_word.lane[i];
			end
		end
	end

endmodule

//--- lsu_align.sv
// byte-lane logic of the load-store unit: places store data and strobes, extracts and extends loads
`timescale 1ns/1ps

module lsu_align (
	input  logic [lsu_pkg::DATA_W-1:0] addr_i,
	input  lsu_pkg::load_type_e        load_type_i,
	input  lsu_pkg::store_type_e       store_type_i,
	input  logic [lsu_pkg::DATA_W-1:0] wdata_i,
	input  logic [lsu_pkg::DATA_W-1:0] rdata_i,
	output logic [lsu_pkg::DATA_W-1:0] bus_addr_o,
	output logic [lsu_pkg::DATA_W-1:0] wdata_o,
	output logic [3:0]                 wstrb_o,
	output logic [lsu_pkg::DATA_W-1:0] load_o
);
	import lsu_pkg::*;

	logic [1:0] offset;
	logic [3:0] base_strb;
	bus_word_u  wsrc;
	bus_word_u  wplaced;
	bus_word_u  rshift;

	assign offset     = addr_i[1:0];
	assign bus_addr_o = {addr_i[DATA_W-1:2], 2'b00};

	// lanes covered by the store before shifting
	always_comb begin
		case (store_type_i)
			ST_B:    base_strb = 4'b0001;
			ST_H:    base_strb = 4'b0011;
			ST_W:    base_strb = 4'b1111;
			default: base_strb = 4'b0000;
		endcase
	end

	// strobes pushed past lane 3 fall off
	assign wstrb_o = base_strb << offset;

	assign wsrc = wdata_i;

	// move each source byte up by the offset
	always_comb begin
		wplaced = '0;
		for (int i = 0; i < DATA_W / 8; i++) begin
			if (i >= int'(offset)) begin
				wplaced.lane[i] = wsrc.lane[i - int'(offset)];
			end
		end
	end

	assign wdata_o = wplaced;

	// returned word brought down to bit 0, upper bytes zero
	assign rshift = rdata_i >> {offset, 3'b000};

	always_comb begin
		case (load_type_i)
			LD_B:    load_o = {{(DATA_W - 8){rshift.lane[0][7]}}, rshift.lane[0]};
			LD_BU:   load_o = {{(DATA_W - 8){1'b0}}, rshift.lane[0]};
			LD_H:    load_o = {{(DATA_W - 16){rshift.half[0][15]}}, rshift.half[0]};
			LD_HU:   load_o = {{(DATA_W - 16){1'b0}}, rshift.half[0]};
			// word loads and anything else pass straight through
			default: load_o = rshift;
		endcase
	end

endmodule

//--- lsu_ctrl.sv
// load-store controller: latches one operation, runs the bus master FSM and registers the result
`timescale 1ns/1ps

module lsu_ctrl (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       start_i,
	input  lsu_pkg::load_type_e        load_type_i,
	input  lsu_pkg::store_type_e       store_type_i,
	input  logic [lsu_pkg::DATA_W-1:0] addr_i,
	input  logic [lsu_pkg::DATA_W-1:0] wdata_i,
	input  logic [4:0]                 rd_i,
	output logic                       busy_o,
	output logic                       done_o,
	output logic                       err_o,
	output logic [4:0]                 rd_o,
	output logic [lsu_pkg::DATA_W-1:0] result_o,
	output logic [lsu_pkg::DATA_W-1:0] ar_addr_o,
	output logic                       ar_valid_o,
	input  logic                       ar_ready_i,
	input  logic [lsu_pkg::DATA_W-1:0] r_data_i,
	input  logic [1:0]                 r_resp_i,
	input  logic                       r_valid_i,
	output logic                       r_ready_o,
	output logic [lsu_pkg::DATA_W-1:0] aw_addr_o,
	output logic                       aw_valid_o,
	input  logic                       aw_ready_i,
	output logic [lsu_pkg::DATA_W-1:0] w_data_o,
	output logic [3:0]                 w_strb_o,
	output logic                       w_valid_o,
	input  logic                       w_ready_i,
	input  logic [1:0]                 b_resp_i,
	input  logic                       b_valid_i,
	output logic                       b_ready_o
);
	import lsu_pkg::*;

	typedef enum logic [1:0] {IDLE, ADDR, RESP, DONE} state_e;

	state_e            state_q;
	state_e            state_d;
	load_type_e        ld_type_q;
	store_type_e       st_type_q;
	logic [DATA_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic [DATA_W-1:0] result_q;
	logic [DATA_W-1:0] bus_addr;
	logic [DATA_W-1:0] load_val;
	logic [4:0]        rd_q;
	logic              err_q;
	logic              aw_sent_q;
	logic              w_sent_q;
	logic              start_mem;
	logic              is_load;
	logic              is_store;
	logic              ar_fire;
	logic              aw_fire;
	logic              w_fire;
	logic              r_fire;
	logic              b_fire;
	logic              write_sent;

	assign start_mem = (load_type_i != LD_NONE) || (store_type_i != ST_NONE);
	// a load wins if both kinds are given
	assign is_load   = ld_type_q != LD_NONE;
	assign is_store  = (st_type_q != ST_NONE) && !is_load;

	// single operation buffer, caller may change its inputs afterwards
	always_ff @(posedge clock) begin
		if (state_q == IDLE && start_i) begin
			ld_type_q <= load_type_i;
			st_type_q <= store_type_i;
			addr_q    <= addr_i;
			wdata_q   <= wdata_i;
			rd_q      <= rd_i;
		end
	end

	lsu_align lsu_align_i (
		.addr_i      (addr_q),
		.load_type_i (ld_type_q),
		.store_type_i(st_type_q),
		.wdata_i     (wdata_q),
		.rdata_i     (r_data_i),
		.bus_addr_o  (bus_addr),
		.wdata_o     (w_data_o),
		.wstrb_o     (w_strb_o),
		.load_o      (load_val)
	);

	assign ar_addr_o  = bus_addr;
	assign aw_addr_o  = bus_addr;
	assign ar_valid_o = (state_q == ADDR) && is_load;
	assign aw_valid_o = (state_q == ADDR) && is_store && !aw_sent_q;
	assign w_valid_o  = (state_q == ADDR) && is_store && !w_sent_q;
	assign r_ready_o  = (state_q == RESP) && is_load;
	assign b_ready_o  = (state_q == RESP) && is_store;

	assign ar_fire    = ar_valid_o && ar_ready_i;
	assign aw_fire    = aw_valid_o && aw_ready_i;
	assign w_fire     = w_valid_o && w_ready_i;
	assign r_fire     = r_valid_i && r_ready_o;
	assign b_fire     = b_valid_i && b_ready_o;
	// write counts as sent once address and data have both gone
	assign write_sent = (aw_sent_q || aw_fire) && (w_sent_q || w_fire);

	always_ff @(posedge clock) begin
		if (!rstn || state_d != ADDR) begin
			aw_sent_q <= 1'b0;
			w_sent_q  <= 1'b0;
		end else begin
			if (aw_fire) aw_sent_q <= 1'b1;
			if (w_fire) w_sent_q <= 1'b1;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: if (start_i) state_d = start_mem ? ADDR : DONE;
			ADDR: if (ar_fire || write_sent) state_d = RESP;
			RESP: if (r_fire || b_fire) state_d = DONE;
			DONE: state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstn) state_q <= IDLE;
		else state_q <= state_d;
	end

	// non-memory result is just the address, known at start
	always_ff @(posedge clock) begin
		if (state_q == IDLE && start_i && !start_mem) result_q <= addr_i;
		else if (r_fire) result_q <= load_val;
		else if (b_fire) result_q <= '0;
	end

	always_ff @(posedge clock) begin
		if (!rstn) err_q <= 1'b0;
		else if (state_q == IDLE && start_i && !start_mem) err_q <= 1'b0;
		else if (r_fire) err_q <= r_resp_i != RESP_OKAY;
		else if (b_fire) err_q <= b_resp_i != RESP_OKAY;
	end

	assign busy_o   = state_q != IDLE;
	assign done_o   = state_q == DONE;
	assign err_o    = err_q;
	assign rd_o     = rd_q;
	assign result_o = result_q;

endmodule

//--- lsu_pkg.sv
// shared constants, operation codes and bus word views for the load-store unit and its memory
package lsu_pkg;

	// bus and register width
	localparam int DATA_W = 32;

	// load kinds, nonzero means the operation reads memory
	typedef enum logic [2:0] {
		LD_NONE = 3'd0,
		LD_B    = 3'd1,
		LD_H    = 3'd2,
		LD_W    = 3'd3,
		LD_BU   = 3'd4,
		LD_HU   = 3'd5
	} load_type_e;

	// store kinds, nonzero means the operation writes memory
	typedef enum logic [1:0] {
		ST_NONE = 2'd0,
		ST_B    = 2'd1,
		ST_H    = 2'd2,
		ST_W    = 2'd3
	} store_type_e;

	// bus response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// one bus word, seen as byte lanes or as halfwords
	typedef union packed {
		logic [DATA_W/8-1:0][7:0]   lane;
		logic [DATA_W/16-1:0][15:0] half;
	} bus_word_u;

endpackage

//--- lsu_top.sv
// top level of the load-store unit: controller and data memory joined by the internal bus
`timescale 1ns/1ps

module lsu_top #(
	parameter int DEPTH_WORDS = 256,
	parameter int READY_WAIT  = 0,
	parameter int RESP_WAIT   = 0
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       start_i,
	input  lsu_pkg::load_type_e        load_type_i,
	input  lsu_pkg::store_type_e       store_type_i,
	input  logic [lsu_pkg::DATA_W-1:0] addr_i,
	input  logic [lsu_pkg::DATA_W-1:0] wdata_i,
	input  logic [4:0]                 rd_i,
	output logic                       busy_o,
	output logic                       done_o,
	output logic                       err_o,
	output logic [4:0]                 rd_o,
	output logic [lsu_pkg::DATA_W-1:0] result_o
);
	import lsu_pkg::*;

	// read channels
	logic [DATA_W-1:0] ar_addr;
	logic              ar_valid;
	logic              ar_ready;
	logic [DATA_W-1:0] r_data;
	logic [1:0]        r_resp;
	logic              r_valid;
	logic              r_ready;
	// write channels
	logic [DATA_W-1:0] aw_addr;
	logic              aw_valid;
	logic              aw_ready;
	logic [DATA_W-1:0] w_data;
	logic [3:0]        w_strb;
	logic              w_valid;
	logic              w_ready;
	logic [1:0]        b_resp;
	logic              b_valid;
	logic              b_ready;

	lsu_ctrl lsu_ctrl_i (
		.clock       (clock),
		.rstn        (rstn),
		.start_i     (start_i),
		.load_type_i (load_type_i),
		.store_type_i(store_type_i),
		.addr_i      (addr_i),
		.wdata_i     (wdata_i),
		.rd_i        (rd_i),
		.busy_o      (busy_o),
		.done_o      (done_o),
		.err_o       (err_o),
		.rd_o        (rd_o),
		.result_o    (result_o),
		.ar_addr_o   (ar_addr),
		.ar_valid_o  (ar_valid),
		.ar_ready_i  (ar_ready),
		.r_data_i    (r_data),
		.r_resp_i    (r_resp),
		.r_valid_i   (r_valid),
		.r_ready_o   (r_ready),
		.aw_addr_o   (aw_addr),
		.aw_valid_o  (aw_valid),
		.aw_ready_i  (aw_ready),
		.w_data_o    (w_data),
		.w_strb_o    (w_strb),
		.w_valid_o   (w_valid),
		.w_ready_i   (w_ready),
		.b_resp_i    (b_resp),
		.b_valid_i   (b_valid),
		.b_ready_o   (b_ready)
	);

	data_sram #(
		.DEPTH_WORDS(DEPTH_WORDS),
		.READY_WAIT (READY_WAIT),
		.RESP_WAIT  (RESP_WAIT)
	) data_sram_i (
		.clock     (clock),
		.rstn      (rstn),
		.ar_addr_i (ar_addr),
		.ar_valid_i(ar_valid),
		.ar_ready_o(ar_ready),
		.r_data_o  (r_data),
		.r_resp_o  (r_resp),
		.r_valid_o (r_valid),
		.r_ready_i (r_ready),
		.aw_addr_i (aw_addr),
		.aw_valid_i(aw_valid),
		.aw_ready_o(aw_ready),
		.w_data_i  (w_data),
		.w_strb_i  (w_strb),
		.w_valid_i (w_valid),
		.w_ready_o (w_ready),
		.b_resp_o  (b_resp),
		.b_valid_o (b_valid),
		.b_ready_i (b_ready)
	);

endmodule

//--- tb_lsu.sv
// directed testbench for lsu_top: runs word, sub-word, non-memory, out-of-range and random operations
`timescale 1ns/1ps

module tb_lsu;
	import lsu_pkg::*;

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 8;
	localparam int IDLE_CYCLES  = 20;
	localparam int DEPTH        = 64;
	localparam int DONE_LIMIT   = 30;
	localparam int RANDOM_OPS   = 200;
	// word test, sub-word stores, sub-word loads, range test, fill, random mix
	localparam int NUM_OPS      = 16 + 20 + 17 + 5 + DEPTH + RANDOM_OPS;

	logic              clock;
	logic              rstn;
	logic              start_i;
	load_type_e        load_type;
	store_type_e       store_type;
	logic [DATA_W-1:0] addr_in;
	logic [DATA_W-1:0] wdata_in;
	logic [4:0]        rd_in;
	logic              busy_o;
	logic              done_o;
	logic              err_o;
	logic [4:0]        rd_o;
	logic [DATA_W-1:0] result_o;

	// expected memory contents, byte address bits 7:2 pick the word
	logic [31:0] model_mem [DEPTH];
	logic [31:0] lcg_state = 32'h33eb_bdf7;

	lsu_top #(
		.DEPTH_WORDS(DEPTH),
		.READY_WAIT (2),
		.RESP_WAIT  (3)
	) lsu_top_i (
		.clock       (clock),
		.rstn        (rstn),
		.start_i     (start_i),
		.load_type_i (load_type),
		.store_type_i(store_type),
		.addr_i      (addr_in),
		.wdata_i     (wdata_in),
		.rd_i        (rd_in),
		.busy_o      (busy_o),
		.done_o      (done_o),
		.err_o       (err_o),
		.rd_o        (rd_o),
		.result_o    (result_o)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#((NUM_OPS * DONE_LIMIT + RESET_CYCLES + IDLE_CYCLES) * CLK_PERIOD);
		$display("watchdog expired, the run took longer than all tests should");
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped by watchdog");
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// pattern that changes with every bit of the address
	function automatic logic [31:0] fill_word(logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[15:0]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
			$display("CHECKS FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// word shifted down by the byte offset, then extended by load kind
	function automatic logic [31:0] expect_load(load_type_e lt, logic [31:0] addr);
		logic [31:0] w;
		w = model_mem[addr[7:2]] >> {addr[1:0], 3'b000};
		case (lt)
			LD_B:    return {{24{w[7]}}, w[7:0]};
			LD_BU:   return {24'h0, w[7:0]};
			LD_H:    return {{16{w[15]}}, w[15:0]};
			LD_HU:   return {16'h0, w[15:0]};
			default: return w;
		endcase
	endfunction

	// lanes and data move up by the offset, anything past lane 3 is lost
	task automatic model_store(input store_type_e st, input logic [31:0] addr,
			input logic [31:0] data);
		logic [3:0]  lanes;
		logic [31:0] placed;
		lanes = (st == ST_B) ? 4'b0001 : (st == ST_H) ? 4'b0011 : 4'b1111;
		lanes = lanes << addr[1:0];
		placed = data << {addr[1:0], 3'b000};
		for (int i = 0; i < 4; i++) begin
			if (lanes[i]) model_mem[addr[7:2]][8*i +: 8] = placed[8*i +: 8];
		end
	endtask

	task automatic run_op(input load_type_e lt, input store_type_e st,
			input logic [31:0] addr, input logic [31:0] data, input logic [4:0] rd,
			output int cycles);
		logic [31:0] exp_result;
		logic        exp_err;
		logic        in_range;
		in_range = addr < 32'(4 * DEPTH);
		exp_err = !in_range && (lt != LD_NONE || st != ST_NONE);
		if (lt != LD_NONE) exp_result = in_range ? expect_load(lt, addr) : 32'h0;
		else if (st != ST_NONE) exp_result = 32'h0;
		else exp_result = addr;
		@(posedge clock);
		#1;
		start_i = 1'b1;
		load_type = lt;
		store_type = st;
		addr_in = addr;
		wdata_in = data;
		rd_in = rd;
		@(posedge clock);
		#1;
		start_i = 1'b0;
		// the controller keeps its own copy, so garble the inputs
		addr_in = ~addr;
		wdata_in = ~data;
		rd_in = ~rd;
		cycles = 1;
		while (!done_o) begin
			// busy for the whole operation
			check_value("busy_o", 32'(busy_o), 32'h1);
			if (cycles >= DONE_LIMIT) begin
				$display("done never arrived for the operation at address 0x%08h", addr);
				$display("CHECKS FAILED");
				$fatal(1, "operation timed out");
			end
			@(posedge clock);
			#1;
			cycles++;
		end
		check_value("busy_o", 32'(busy_o), 32'h1);
		check_value("result_o", result_o, exp_result);
		check_value("rd_o", 32'(rd_o), 32'(rd));
		check_value("err_o", 32'(err_o), 32'(exp_err));
		if (lt == LD_NONE && st != ST_NONE && in_range) model_store(st, addr, data);
	endtask

	task automatic reset_state();
		rstn = 1'b0;
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clock);
			#1;
			check_value("busy_o", 32'(busy_o), 32'h0);
			check_value("done_o", 32'(done_o), 32'h0);
			check_value("err_o", 32'(err_o), 32'h0);
		end
		rstn = 1'b1;
		for (int i = 0; i < IDLE_CYCLES; i++) begin
			@(posedge clock);
			#1;
			check_value("done_o", 32'(done_o), 32'h0);
			check_value("busy_o", 32'(busy_o), 32'h0);
		end
	endtask

	task automatic word_store_load();
		logic [31:0] addrs [8];
		int          cycles;
		addrs = '{32'h04, 32'h08, 32'h3c, 32'h80, 32'ha4, 32'hc0, 32'hf8, 32'hfc};
		for (int i = 0; i < 8; i++) begin
			run_op(LD_NONE, ST_W, addrs[i], lcg_next(), 5'(i + 1), cycles);
		end
		for (int i = 0; i < 8; i++) begin
			run_op(LD_W, ST_NONE, addrs[i], 32'h0, 5'(i + 10), cycles);
		end
	endtask

	task automatic subword_stores();
		logic [31:0] base;
		int          cycles;
		for (int off = 0; off < 4; off++) begin
			base = 32'h20 + 32'(4 * off);
			run_op(LD_NONE, ST_W, base, 32'h1122_3344, 5'd3, cycles);
			run_op(LD_NONE, ST_B, base + 32'(off), 32'h7766_55a5, 5'd4, cycles);
			run_op(LD_W, ST_NONE, base, 32'h0, 5'd5, cycles);
			run_op(LD_NONE, ST_H, base + 32'(off), 32'h99aa_c3d2, 5'd6, cycles);
			run_op(LD_W, ST_NONE, base, 32'h0, 5'd7, cycles);
		end
	endtask

	task automatic subword_loads();
		load_type_e kinds [4];
		int         cycles;
		kinds = '{LD_B, LD_BU, LD_H, LD_HU};
		// every byte has its top bit set
		run_op(LD_NONE, ST_W, 32'h40, 32'h9cf0_81a7, 5'd8, cycles);
		for (int off = 0; off < 4; off++) begin
			for (int k = 0; k < 4; k++) begin
				run_op(kinds[k], ST_NONE, 32'h40 + 32'(off), 32'h0, 5'(off * 4 + k), cycles);
			end
		end
	endtask

	task automatic nonmem_and_range();
		int cycles;
		run_op(LD_W, ST_NONE, 32'h0000_0100, 32'h0, 5'd11, cycles);
		run_op(LD_BU, ST_NONE, 32'hffff_fffd, 32'h0, 5'd12, cycles);
		// would alias word 1 if the write were not blocked
		run_op(LD_NONE, ST_W, 32'h0000_0104, 32'hffff_ffff, 5'd13, cycles);
		// error flag left by the store above has to clear
		run_op(LD_NONE, ST_NONE, 32'hdead_beef, 32'h0, 5'd9, cycles);
		// done follows in the cycle right after the start cycle
		check_value("done latency", 32'(cycles), 32'd1);
		run_op(LD_W, ST_NONE, 32'h0000_0004, 32'h0, 5'd14, cycles);
	endtask

	task automatic random_mix();
		logic [31:0] r;
		logic [31:0] addr;
		load_type_e  lt;
		store_type_e st;
		int          cycles;
		for (int i = 0; i < DEPTH; i++) begin
			run_op(LD_NONE, ST_W, 32'(4 * i), fill_word(32'(4 * i)), 5'd0, cycles);
		end
		for (int n = 0; n < RANDOM_OPS; n++) begin
			r = lcg_next();
			addr = {24'h0, r[13:8], r[15:14]};
			lt = LD_NONE;
			st = ST_NONE;
			case (r[31:28] % 4'd10)
				4'd0, 4'd1, 4'd2, 4'd3: begin
					case (r[23:20] % 4'd5)
						4'd0: lt = LD_B;
						4'd1: lt = LD_H;
						4'd2: lt = LD_W;
						4'd3: lt = LD_BU;
						default: lt = LD_HU;
					endcase
				end
				4'd4, 4'd5, 4'd6, 4'd7: begin
					case (r[23:20] % 4'd3)
						4'd0: st = ST_B;
						4'd1: st = ST_H;
						default: st = ST_W;
					endcase
				end
				default: addr = lcg_next();
			endcase
			run_op(lt, st, addr, lcg_next(), r[4:0], cycles);
		end
	endtask

	initial begin
		rstn = 1'b0;
		start_i = 1'b0;
		load_type = LD_NONE;
		store_type = ST_NONE;
		addr_in = '0;
		wdata_in = '0;
		rd_in = '0;
		reset_state();
		word_store_load();
		subword_stores();
		subword_loads();
		nonmem_and_range();
		random_mix();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
